// File: hba_config.svh
`ifndef HBA_CONFIG_SVH
`define HBA_CONFIG_SVH

// uart bit time in clocks, kept short for simulation
// a 50 MHz board clock at 115200 baud needs about 434 here
`define HBA_BAUD_DIV          8

// cycles the system reset stays up after the board reset drops
`define HBA_RESET_HOLD        10

// peripheral slot numbers on the bus, slot 0 is the bridge itself
`define HBA_SLOT_BASICIO      1
`define HBA_SLOT_SONAR        2

`define HBA_BUTTON_COUNT      2   // button pins on the basic io slot

`define HBA_SONAR_CHANNELS    2
`define HBA_SONAR_TRIG_CYCLES 10  // trigger pulse width
`define HBA_SONAR_TICK_CYCLES 4   // clocks per echo width unit

`endif

// File: hba_pkg.sv
package hba_pkg;

    // one word on the peripheral data bus
    typedef logic [7:0] hba_data_t;

    // peripheral slot and register index within a slot
    typedef logic [2:0] hba_slot_t;
    typedef logic [3:0] hba_reg_t;

    // serial command byte from the host
    // msb first: rd flag, slot, register
    // rd = 0 means one data byte follows and gets written
    // rd = 1 means the bridge replies with one byte
    typedef struct packed {
        logic      rd;
        hba_slot_t slot;
        hba_reg_t  reg_idx;
    } hba_cmd_t;

endpackage

// File: hba_serial_bridge.sv
`timescale 1ns/1ns
`include "hba_config.svh"

module hba_serial_bridge (
    input  logic               clk,
    input  logic               reset,
    input  logic               rxd,        // from host, idle high
    output logic               txd,        // to host, idle high
    input  hba_pkg::hba_data_t bus_rdata,  // or of all slot rdata
    output hba_pkg::hba_slot_t bus_slot,
    output hba_pkg::hba_reg_t  bus_reg,
    output hba_pkg::hba_data_t bus_wdata,
    output logic               bus_wr,     // one cycle strobe
    output logic               bus_rd      // one cycle strobe
);
    import hba_pkg::*;

    localparam int BAUD_DIV = `HBA_BAUD_DIV;
    localparam int TMR_W    = $clog2(BAUD_DIV + 1);

    // receiver states
    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    // command parser states
    localparam logic [2:0] BR_CMD   = 3'd0;  // wait for command byte
    localparam logic [2:0] BR_DATA  = 3'd1;  // wait for write data byte
    localparam logic [2:0] BR_RD1   = 3'd2;  // bus_rd high
    localparam logic [2:0] BR_RD2   = 3'd3;  // slot drives rdata
    localparam logic [2:0] BR_REPLY = 3'd4;  // reply byte on txd

    logic             rxd_meta;
    logic             rxd_sync;
    logic [1:0]       rx_state;
    logic [TMR_W-1:0] rx_timer;
    logic [2:0]       rx_bit;
    hba_data_t        rx_shift;
    logic             rx_done;
    hba_cmd_t         rx_cmd;

    logic [2:0]       br_state;

    logic             tx_start;
    hba_data_t        tx_byte;
    logic             tx_busy;
    logic [TMR_W-1:0] tx_timer;
    logic [3:0]       tx_bits;
    logic [8:0]       tx_shift;   // data then stop bit

    // stop bit sampled high at mid-bit, frame is good
    assign rx_done = (rx_state == RX_STOP) && (rx_timer == '0) && rxd_sync;
    assign rx_cmd  = hba_cmd_t'(rx_shift);

    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rx_state <= RX_IDLE;
            rx_timer <= '0;
            rx_bit   <= '0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            if (rx_state != RX_IDLE && rx_timer != '0) begin
                rx_timer <= rx_timer - 1'b1;
            end else begin
                case (rx_state)
                    RX_IDLE: if (!rxd_sync) begin
                        rx_state <= RX_START;
                        rx_timer <= TMR_W'(BAUD_DIV / 2 - 1);  // go to mid-bit
                    end
                    RX_START: begin
                        // glitch shorter than half a bit goes back to idle
                        rx_state <= rxd_sync ? RX_IDLE : RX_DATA;
                        rx_timer <= TMR_W'(BAUD_DIV - 1);
                        rx_bit   <= '0;
                    end
                    RX_DATA: begin
                        rx_timer <= TMR_W'(BAUD_DIV - 1);
                        rx_bit   <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7)
                            rx_state <= RX_STOP;
                    end
                    default: rx_state <= RX_IDLE;  // stop bit done
                endcase
            end
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && rx_timer == '0)
            rx_shift <= {rxd_sync, rx_shift[7:1]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            br_state <= BR_CMD;
            bus_wr   <= 1'b0;
            bus_rd   <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            bus_wr   <= 1'b0;
            bus_rd   <= 1'b0;
            tx_start <= 1'b0;
            case (br_state)
                BR_CMD: if (rx_done) begin
                    bus_rd   <= rx_cmd.rd;
                    br_state <= rx_cmd.rd ? BR_RD1 : BR_DATA;
                end
                BR_DATA: if (rx_done) begin
                    bus_wr   <= 1'b1;
                    br_state <= BR_CMD;
                end
                BR_RD1: br_state <= BR_RD2;
                BR_RD2: begin
                    tx_start <= 1'b1;   // bus_rdata valid now
                    br_state <= BR_REPLY;
                end
                default: if (!tx_busy && !tx_start)
                    br_state <= BR_CMD;  // bytes during reply are dropped
            endcase
        end
    end

    // address and payload, no reset needed
    always_ff @(posedge clk) begin
        if (br_state == BR_CMD && rx_done) begin
            bus_slot <= rx_cmd.slot;
            bus_reg  <= rx_cmd.reg_idx;
        end
        if (br_state == BR_DATA && rx_done)
            bus_wdata <= rx_shift;
        if (br_state == BR_RD2)
            tx_byte <= bus_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            txd      <= 1'b1;
            tx_busy  <= 1'b0;
            tx_timer <= '0;
            tx_bits  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                txd      <= 1'b0;        // start bit
                tx_busy  <= 1'b1;
                tx_timer <= TMR_W'(BAUD_DIV - 1);
                tx_bits  <= 4'd9;        // 8 data + stop
            end
        end else if (tx_timer != '0) begin
            tx_timer <= tx_timer - 1'b1;
        end else if (tx_bits != '0) begin
            txd      <= tx_shift[0];
            tx_timer <= TMR_W'(BAUD_DIV - 1);
            tx_bits  <= tx_bits - 1'b1;
        end else begin
            tx_busy  <= 1'b0;            // stop bit fully sent
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start)
            tx_shift <= {1'b1, tx_byte};
        else if (tx_busy && tx_timer == '0 && tx_bits != '0)
            tx_shift <= {1'b1, tx_shift[8:1]};
    end

endmodule

// File: hba_basicio.sv
`timescale 1ns/1ns
`include "hba_config.svh"

module hba_basicio (
    input  logic                         clk,
    input  logic                         reset,
    input  hba_pkg::hba_slot_t           bus_slot,
    input  hba_pkg::hba_reg_t            bus_reg,
    input  hba_pkg::hba_data_t           bus_wdata,
    input  logic                         bus_wr,
    input  logic                         bus_rd,
    input  logic [`HBA_BUTTON_COUNT-1:0] button,        // async pins
    output hba_pkg::hba_data_t           rdata,
    output hba_pkg::hba_data_t           led,
    output logic                         basicio_intr   // level, pending flag
);
    import hba_pkg::*;

    logic                         sel;
    logic [`HBA_BUTTON_COUNT-1:0] btn_meta;
    logic [`HBA_BUTTON_COUNT-1:0] btn_sync;
    logic [`HBA_BUTTON_COUNT-1:0] btn_prev;   // for change detect
    logic                         pending;

    assign sel          = (bus_slot == hba_slot_t'(`HBA_SLOT_BASICIO));
    assign basicio_intr = pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            led      <= '0;
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            pending  <= 1'b0;
        end else begin
            btn_meta <= button;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            if (sel && bus_wr && bus_reg == hba_reg_t'(0))
                led <= bus_wdata;
            // a new change wins over a clear in the same cycle
            if (btn_sync != btn_prev)
                pending <= 1'b1;
            else if (sel && bus_wr && bus_reg == hba_reg_t'(2))
                pending <= 1'b0;  // any write value clears
        end
    end

    // read data one cycle after bus_rd, zero otherwise
    always_ff @(posedge clk) begin
        rdata <= '0;
        if (sel && bus_rd) begin
            case (bus_reg)
                hba_reg_t'(0): rdata <= led;
                hba_reg_t'(1): rdata <= hba_data_t'(btn_sync);
                hba_reg_t'(2): rdata <= hba_data_t'(pending);
                default:       rdata <= '0;  // unmapped
            endcase
        end
    end

endmodule

// File: hba_sonar.sv
`timescale 1ns/1ns
`include "hba_config.svh"

module hba_sonar (
    input  logic                           clk,
    input  logic                           reset,
    input  hba_pkg::hba_slot_t             bus_slot,
    input  hba_pkg::hba_reg_t              bus_reg,
    input  hba_pkg::hba_data_t             bus_wdata,
    input  logic                           bus_wr,
    input  logic                           bus_rd,
    input  logic [`HBA_SONAR_CHANNELS-1:0] sonar_echo,
    output hba_pkg::hba_data_t             rdata,
    output logic [`HBA_SONAR_CHANNELS-1:0] sonar_trig,
    output logic                           sonar_intr   // or of done flags
);
    import hba_pkg::*;

    localparam int CH     = `HBA_SONAR_CHANNELS;
    localparam int TRIG_W = $clog2(`HBA_SONAR_TRIG_CYCLES + 1);
    localparam int TICK_W = $clog2(`HBA_SONAR_TICK_CYCLES + 1);

    // per channel states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_TRIG = 2'd1;  // trigger pulse out
    localparam logic [1:0] ST_WAIT = 2'd2;  // waiting for echo rise
    localparam logic [1:0] ST_MEAS = 2'd3;  // echo high, counting

    logic              sel;
    logic              trig_wr;
    logic              done_wr;
    logic [CH-1:0]     echo_meta;
    logic [CH-1:0]     echo_sync;
    logic [1:0]        ch_state [CH];
    logic [TRIG_W-1:0] trig_cnt [CH];
    logic [TICK_W-1:0] presc    [CH];  // tick prescaler
    hba_data_t         count    [CH];  // live width, saturating
    hba_data_t         width    [CH];  // last finished width
    logic [CH-1:0]     done;
    logic [CH-1:0]     busy;

    assign sel        = (bus_slot == hba_slot_t'(`HBA_SLOT_SONAR));
    assign trig_wr    = sel && bus_wr && (bus_reg == hba_reg_t'(0));
    assign done_wr    = sel && bus_wr && (bus_reg == hba_reg_t'(1));
    assign sonar_intr = |done;

    always_comb begin
        for (int i = 0; i < CH; i++)
            busy[i] = (ch_state[i] != ST_IDLE);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            echo_meta  <= '0;
            echo_sync  <= '0;
            sonar_trig <= '0;
            done       <= '0;
            for (int i = 0; i < CH; i++) begin
                ch_state[i] <= ST_IDLE;
                trig_cnt[i] <= '0;
            end
        end else begin
            echo_meta <= sonar_echo;
            echo_sync <= echo_meta;
            for (int i = 0; i < CH; i++) begin
                case (ch_state[i])
                    ST_IDLE: if (trig_wr && bus_wdata[i]) begin
                        ch_state[i]   <= ST_TRIG;
                        sonar_trig[i] <= 1'b1;
                        trig_cnt[i]   <= TRIG_W'(`HBA_SONAR_TRIG_CYCLES - 1);
                    end
                    ST_TRIG: if (trig_cnt[i] == '0) begin
                        sonar_trig[i] <= 1'b0;
                        ch_state[i]   <= ST_WAIT;
                    end else begin
                        trig_cnt[i] <= trig_cnt[i] - 1'b1;
                    end
                    ST_WAIT: if (echo_sync[i])
                        ch_state[i] <= ST_MEAS;
                    default: if (!echo_sync[i])
                        ch_state[i] <= ST_IDLE;  // echo fell
                endcase
                // falling edge sets done, clear needs a 1 in that bit
                if (ch_state[i] == ST_MEAS && !echo_sync[i])
                    done[i] <= 1'b1;
                else if (done_wr && bus_wdata[i])
                    done[i] <= 1'b0;
            end
        end
    end

    // width datapath
    always_ff @(posedge clk) begin
        for (int i = 0; i < CH; i++) begin
            if (ch_state[i] == ST_WAIT && echo_sync[i]) begin
                count[i] <= '0;
                presc[i] <= TICK_W'(1);  // first high cycle counts
            end else if (ch_state[i] == ST_MEAS) begin
                if (!echo_sync[i]) begin
                    width[i] <= count[i];
                end else if (presc[i] == TICK_W'(`HBA_SONAR_TICK_CYCLES - 1)) begin
                    presc[i] <= '0;
                    if (count[i] != 8'hff)
                        count[i] <= count[i] + 1'b1;  // stop at 255
                end else begin
                    presc[i] <= presc[i] + 1'b1;
                end
            end
        end
    end

    // read mux, widths sit at reg 2 upward
    always_ff @(posedge clk) begin
        rdata <= '0;
        if (sel && bus_rd) begin
            if (bus_reg == hba_reg_t'(0))
                rdata <= hba_data_t'(busy);  // channels in flight
            if (bus_reg == hba_reg_t'(1))
                rdata <= hba_data_t'(done);
            for (int i = 0; i < CH; i++) begin
                if (bus_reg == hba_reg_t'(i + 2))
                    rdata <= width[i];
            end
        end
    end

endmodule

// File: hba_system.sv
`timescale 1ns/1ns
`include "hba_config.svh"

module hba_system (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rxd,
    input  logic [`HBA_BUTTON_COUNT-1:0]   button,
    input  logic [`HBA_SONAR_CHANNELS-1:0] sonar_echo,
    output logic                           txd,
    output logic                           intr,       // any slot pending
    output hba_pkg::hba_data_t             led,
    output logic [`HBA_SONAR_CHANNELS-1:0] sonar_trig
);
    import hba_pkg::*;

    // shared peripheral bus
    hba_slot_t bus_slot;
    hba_reg_t  bus_reg;
    hba_data_t bus_wdata;
    logic      bus_wr;
    logic      bus_rd;
    hba_data_t bus_rdata;

    hba_data_t basicio_rdata;   // zero unless slot 1 is read
    hba_data_t sonar_rdata;     // zero unless slot 2 is read
    logic      basicio_intr;
    logic      sonar_intr;

    // unselected slots drive zero so a plain or is enough
    assign bus_rdata = basicio_rdata | sonar_rdata;
    assign intr      = basicio_intr | sonar_intr;

    hba_serial_bridge u_bridge (
        .clk       (clk),
        .reset     (reset),
        .rxd       (rxd),
        .txd       (txd),
        .bus_rdata (bus_rdata),
        .bus_slot  (bus_slot),
        .bus_reg   (bus_reg),
        .bus_wdata (bus_wdata),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd)
    );

    hba_basicio u_basicio (
        .clk          (clk),
        .reset        (reset),
        .bus_slot     (bus_slot),
        .bus_reg      (bus_reg),
        .bus_wdata    (bus_wdata),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .button       (button),
        .rdata        (basicio_rdata),
        .led          (led),
        .basicio_intr (basicio_intr)
    );

    hba_sonar u_sonar (
        .clk        (clk),
        .reset      (reset),
        .bus_slot   (bus_slot),
        .bus_reg    (bus_reg),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .sonar_echo (sonar_echo),
        .rdata      (sonar_rdata),
        .sonar_trig (sonar_trig),
        .sonar_intr (sonar_intr)
    );

endmodule

// File: board_top.sv
`timescale 1ns/1ns
`include "hba_config.svh"

module board_top (
    input  logic                           clk,        // board oscillator, no pll
    input  logic                           reset,      // board reset pin
    input  logic                           rxd,
    input  logic [`HBA_BUTTON_COUNT-1:0]   button,
    input  logic [`HBA_SONAR_CHANNELS-1:0] sonar_echo,
    output logic                           txd,
    output logic                           intr,
    output hba_pkg::hba_data_t             led,
    output logic [`HBA_SONAR_CHANNELS-1:0] sonar_trig
);
    localparam int HOLD   = `HBA_RESET_HOLD;
    localparam int HOLD_W = $clog2(HOLD + 1);

    logic [HOLD_W-1:0] hold_cnt;
    logic              sys_reset;

    // stretch reset so every block sees a clean multi-cycle reset
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt  <= '0;
            sys_reset <= 1'b1;
        end else if (hold_cnt != HOLD_W'(HOLD - 1)) begin
            hold_cnt  <= hold_cnt + 1'b1;
            sys_reset <= 1'b1;
        end else begin
            sys_reset <= 1'b0;  // counter parks here
        end
    end

    hba_system u_hba_system (
        .clk        (clk),
        .reset      (sys_reset),
        .rxd        (rxd),
        .button     (button),      // button pins in slot order
        .sonar_echo (sonar_echo),
        .txd        (txd),
        .intr       (intr),
        .led        (led),
        .sonar_trig (sonar_trig)
    );

endmodule

// File: tb_top.sv
`timescale 1ns/1ns
`include "hba_config.svh"

module tb_top;
    import hba_pkg::*;

    localparam int BAUD = `HBA_BAUD_DIV;
    localparam int BC   = `HBA_BUTTON_COUNT;
    localparam int CH   = `HBA_SONAR_CHANNELS;
    localparam int TRIG = `HBA_SONAR_TRIG_CYCLES;
    localparam int TICK = `HBA_SONAR_TICK_CYCLES;

    logic          clk;
    logic          reset;
    logic          rxd;
    logic [BC-1:0] button;
    logic [CH-1:0] sonar_echo;
    logic          txd;
    logic          intr;
    hba_data_t     led;
    logic [CH-1:0] sonar_trig;

    logic [31:0]   lfsr_state;
    int            checks;
    int            errors;
    int            timeouts;

    // register model of the two slots
    hba_data_t     model_led;
    logic          model_pending;
    logic [BC-1:0] model_button;   // last value driven on the pins
    logic [CH-1:0] model_done;
    hba_data_t     model_width [CH];

    board_top u_board_top (
        .clk        (clk),
        .reset      (reset),
        .rxd        (rxd),
        .button     (button),
        .sonar_echo (sonar_echo),
        .txd        (txd),
        .intr       (intr),
        .led        (led),
        .sonar_trig (sonar_trig)
    );

    always #20 clk = ~clk;  // 40 ns period

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic expected_intr();
        return model_pending | (|model_done);  // both slots or'd
    endfunction

    function automatic logic is_mapped(input hba_slot_t slot, input hba_reg_t ridx);
        if (slot == hba_slot_t'(`HBA_SLOT_BASICIO))
            return ridx <= hba_reg_t'(2);
        if (slot == hba_slot_t'(`HBA_SLOT_SONAR))
            return ridx <= hba_reg_t'(3);
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s expected %0h actual %0h", name, exp, got);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout: %s", what);
    endtask

    // one uart bit, driven on the rising edge
    task automatic send_bit(input logic b);
        @(posedge clk);
        rxd <= b;
        repeat (BAUD - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        send_bit(1'b0);                 // start
        for (int i = 0; i < 8; i++)
            send_bit(b[i]);             // lsb first
        send_bit(1'b1);                 // stop
    endtask

    task automatic write_reg(input hba_slot_t slot, input hba_reg_t ridx,
                             input hba_data_t data);
        hba_cmd_t cmd;
        cmd.rd      = 1'b0;
        cmd.slot    = slot;
        cmd.reg_idx = ridx;
        send_byte(cmd);
        send_byte(data);
    endtask

    task automatic read_reg(input hba_slot_t slot, input hba_reg_t ridx,
                            output hba_data_t data);
        hba_cmd_t cmd;
        int       n;
        cmd.rd      = 1'b1;
        cmd.slot    = slot;
        cmd.reg_idx = ridx;
        data        = '0;
        send_byte(cmd);
        n = 0;
        while (txd !== 1'b0 && n < 8 * BAUD) begin  // reply start bit
            @(negedge clk);
            n++;
        end
        if (txd !== 1'b0) begin
            report_timeout("no start bit from the bridge on txd");
        end else begin
            repeat (BAUD / 2) @(negedge clk);     // to mid-bit
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD) @(negedge clk);
                data[i] = txd;
            end
            repeat (BAUD) @(negedge clk);
            check_value("read_reg stop bit", 1, txd);
            repeat (BAUD) @(negedge clk);         // let the bridge go idle
        end
    endtask

    task automatic wait_intr(input logic exp, input string name);
        int n;
        n = 0;
        while (intr !== exp && n < 16) begin
            @(negedge clk);
            n++;
        end
        check_value(name, exp, intr);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("reset_state txd", 1, txd);
        check_value("reset_state intr", 0, intr);
        check_value("reset_state led", 0, led);
        check_value("reset_state sonar_trig", 0, sonar_trig);
    endtask

    task automatic test_led_write_read();
        hba_data_t data;
        hba_data_t got;
        int        n;
        for (int iter = 0; iter < 6; iter++) begin
            data = hba_data_t'(rand_bits(8));
            write_reg(hba_slot_t'(`HBA_SLOT_BASICIO), hba_reg_t'(0), data);
            model_led = data;
            n = 0;
            while (led !== data && n < 8) begin  // takes effect after bus_wr
                @(negedge clk);
                n++;
            end
            check_value("led_write_read pins", model_led, led);
            read_reg(hba_slot_t'(`HBA_SLOT_BASICIO), hba_reg_t'(0), got);
            check_value("led_write_read reg0", model_led, got);
        end
    endtask

    task automatic test_button_pending();
        logic [BC-1:0] btn;
        hba_data_t     got;
        for (int iter = 0; iter < 8; iter++) begin
            btn = BC'(rand_bits(BC));
            @(posedge clk);
            button <= btn;
            if (btn != model_button)
                model_pending = 1'b1;
            model_button = btn;
            wait_intr(expected_intr(), "button_pending intr");
            read_reg(hba_slot_t'(`HBA_SLOT_BASICIO), hba_reg_t'(1), got);
            check_value("button_pending reg1", hba_data_t'(btn), got);
            read_reg(hba_slot_t'(`HBA_SLOT_BASICIO), hba_reg_t'(2), got);
            check_value("button_pending reg2", hba_data_t'(model_pending), got);
            if (rand_bits(1) != 0 || iter == 7) begin
                // any value clears the flag
                write_reg(hba_slot_t'(`HBA_SLOT_BASICIO), hba_reg_t'(2),
                          hba_data_t'(rand_bits(8)));
                model_pending = 1'b0;
                wait_intr(expected_intr(), "button_pending clear intr");
            end
        end
    endtask

    task automatic test_sonar_measure();
        logic [CH-1:0] mask;
        hba_data_t     got;
        int            ticks;
        int            high_cycles;
        int            n;
        for (int iter = 0; iter < 4; iter++) begin
            mask = CH'(rand_bits(CH));
            if (mask == '0)
                mask = '1;
            write_reg(hba_slot_t'(`HBA_SLOT_SONAR), hba_reg_t'(0), hba_data_t'(mask));
            n = 0;
            while ((sonar_trig & mask) == '0 && n < 4 * BAUD) begin
                @(negedge clk);
                n++;
            end
            if ((sonar_trig & mask) == '0)
                report_timeout("sonar trigger pulse never started");
            check_value("sonar_measure trig mask", mask, sonar_trig);
            high_cycles = 0;
            while (sonar_trig != '0 && high_cycles < 4 * TRIG) begin
                high_cycles++;
                @(negedge clk);
            end
            check_value("sonar_measure trig width", TRIG, high_cycles);
            for (int ch = 0; ch < CH; ch++) begin
                if (mask[ch]) begin
                    // sometimes long enough to saturate
                    if (rand_bits(1) != 0)
                        ticks = 256 + int'(rand_bits(6));
                    else
                        ticks = 1 + int'(rand_bits(8));
                    @(posedge clk);
                    sonar_echo[ch] <= 1'b1;
                    repeat (ticks * TICK) @(posedge clk);
                    sonar_echo[ch] <= 1'b0;
                    model_width[ch] = (ticks > 255) ? 8'hff : hba_data_t'(ticks);
                    model_done[ch]  = 1'b1;
                    wait_intr(1'b1, "sonar_measure intr");
                end
            end
            read_reg(hba_slot_t'(`HBA_SLOT_SONAR), hba_reg_t'(1), got);
            check_value("sonar_measure done", hba_data_t'(model_done), got);
            for (int ch = 0; ch < CH; ch++) begin
                if (mask[ch]) begin
                    read_reg(hba_slot_t'(`HBA_SLOT_SONAR), hba_reg_t'(ch + 2), got);
                    check_value("sonar_measure width", model_width[ch], got);
                end
            end
            // clear only the bits written as 1
            write_reg(hba_slot_t'(`HBA_SLOT_SONAR), hba_reg_t'(1), hba_data_t'(model_done));
            model_done = '0;
            wait_intr(expected_intr(), "sonar_measure clear intr");
            read_reg(hba_slot_t'(`HBA_SLOT_SONAR), hba_reg_t'(1), got);
            check_value("sonar_measure done cleared", 0, got);
        end
    endtask

    task automatic test_unmapped_reads();
        hba_slot_t slot;
        hba_reg_t  ridx;
        hba_data_t got;
        // flag left pending so a stray clear drops intr
        @(posedge clk);
        button <= ~model_button;
        model_button  = ~model_button;
        model_pending = 1'b1;
        wait_intr(expected_intr(), "unmapped_reads pending intr");
        for (int iter = 0; iter < 12; iter++) begin
            do begin
                slot = hba_slot_t'(rand_bits(3));
                ridx = hba_reg_t'(rand_bits(4));
            end while (is_mapped(slot, ridx));
            if (rand_bits(1) != 0)
                write_reg(slot, ridx, hba_data_t'(rand_bits(8)));  // must hit nothing
            read_reg(slot, ridx, got);
            check_value("unmapped_reads data", 0, got);
            check_value("unmapped_reads led", model_led, led);
            check_value("unmapped_reads intr", expected_intr(), intr);
        end
        read_reg(hba_slot_t'(`HBA_SLOT_BASICIO), hba_reg_t'(0), got);
        check_value("unmapped_reads led reg0", model_led, got);
        read_reg(hba_slot_t'(`HBA_SLOT_BASICIO), hba_reg_t'(2), got);
        check_value("unmapped_reads pending reg2", hba_data_t'(model_pending), got);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        rxd           = 1'b1;          // uart idle
        button        = '0;
        sonar_echo    = '0;
        lfsr_state    = 32'h9f79_6fee;
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        model_led     = '0;
        model_pending = 1'b0;
        model_button  = '0;
        model_done    = '0;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (`HBA_RESET_HOLD + 2) @(posedge clk);  // reset stretch in board_top

        test_reset_state();
        test_led_write_read();
        test_button_pending();
        test_sonar_measure();
        test_unmapped_reads();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
hba_pkg.sv
hba_serial_bridge.sv
hba_basicio.sv
hba_sonar.sv
hba_system.sv
board_top.sv
tb_top.sv

// File: Bender.yml
package:
  name: hba_adapter

export_include_dirs:
  - .

sources:
  - hba_pkg.sv
  - hba_serial_bridge.sv
  - hba_basicio.sv
  - hba_sonar.sv
  - hba_system.sv
  - board_top.sv
  - target: test
    files:
      - tb_top.sv
